// File: Bender.yml
package:
  name: clic_slice

sources:
  # RTL in compile order
  - source/clic_pkg.sv
  - source/clic_reg_bank.sv
  - source/clic_arbiter.sv
  - source/clic_irq_ctrl.sv
  - source/clic_top.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/clic_checker.sv
      - sim/tb_clic.sv

// File: all.f
source/clic_pkg.sv
source/clic_reg_bank.sv
source/clic_arbiter.sv
source/clic_irq_ctrl.sv
source/clic_top.sv
sim/clic_checker.sv
sim/tb_clic.sv

// File: sim/clic_checker.sv
/*
  Concurrent checks on the interrupt control block. Bound into
  clic_irq_ctrl from the testbench, fail_cnt counts failed assertions.
  The in-flight state is tracked here from the handshake lines.
*/
`timescale 1ns/1ns

module clic_checker (
  input logic                  clk_i,
  input logic                  rst_ni,
  input clic_pkg::hart_state_t hart_state_i,
  input clic_pkg::clic_irq_t   sel_irq_i,
  input logic                  irq_ready_i,
  input logic                  kill_req_i,
  input logic                  irq_req_i,
  input clic_pkg::cause_t      irq_cause_i,
  input logic                  kill_ack_i
);

  int unsigned      fail_cnt;
  clic_pkg::level_t m_limit;  // Larger of mintthresh and mil
  logic             busy_q;   // Interrupt in flight

  initial fail_cnt = 0;

  assign m_limit = (hart_state_i.mintthresh >= hart_state_i.mil) ?
                   hart_state_i.mintthresh : hart_state_i.mil;

  // In flight from a request until ready or ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (irq_ready_i || kill_ack_i) begin
      busy_q <= 1'b0;
    end else if (irq_req_i) begin
      busy_q <= 1'b1;
    end
  end

  // ----------------------------------------
  // Properties
  // ----------------------------------------
  // Flag in 31, level in 23:16, id at the bottom, rest zero
  cause_format: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_i |-> (irq_cause_i[31] &&
                   (irq_cause_i[23:16] == sel_irq_i.level) &&
                   (irq_cause_i[clic_pkg::IdWidth-1:0] == sel_irq_i.id) &&
                   ((irq_cause_i & ~32'h80ff_000f) == '0)))
    else begin
      $error("cause word does not match the selected interrupt");
      fail_cnt++;
    end

  // Ack exactly when asked with an idle pipeline
  kill_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kill_ack_i == (kill_req_i && !busy_q && !irq_req_i))
    else begin
      $error("kill acknowledge disagrees with the in-flight state");
      fail_cnt++;
    end

  req_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_i |-> sel_irq_i.valid)
    else begin
      $error("request raised without a valid selection");
      fail_cnt++;
    end

  // In M-mode only M sources above the limit
  m_mode_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_req_i && (hart_state_i.priv_lvl == clic_pkg::PrivM)) |->
      ((sel_irq_i.priv == clic_pkg::PrivM) && (sel_irq_i.level > m_limit)))
    else begin
      $error("M-mode request at or below the effective threshold");
      fail_cnt++;
    end

endmodule

// File: sim/tb_clic.sv
/*
  Testbench of the CLIC slice. Drives clic_top over APB and the source
  lines, mirrors every written value and checks selection, request,
  cause and the kill handshake against that mirror.
*/
`timescale 1ns/1ns

module tb_clic;

  // Per-test cycle budgets, watchdog is twice their sum
  localparam int unsigned TestCycles = 200 + 300 + 260 + 460 + 80;
  localparam int unsigned WatchdogCycles = 2 * TestCycles;

  logic clk_i, rst_ni;
  clic_pkg::apb_req_t  apb_req;
  clic_pkg::apb_rsp_t  apb_rsp;
  logic [clic_pkg::NumSrc-1:0] irq_src;
  logic irq_ready, kill_req, irq_req, kill_ack;
  clic_pkg::priv_lvl_t irq_priv;
  clic_pkg::cause_t    irq_cause;

  // Mirror of every written value
  logic [clic_pkg::NumSrc-1:0] src_m;
  logic             ie_m  [clic_pkg::NumSrc];
  logic [1:0]       prv_m [clic_pkg::NumSrc];
  clic_pkg::level_t lvl_m [clic_pkg::NumSrc];
  logic [1:0]       hpriv_m;
  logic             sie_m;
  clic_pkg::level_t mth_m, sth_m, mil_m, sil_m;

  logic [31:0] rand_state;
  int errors, checks, tests, err_mark;

  clic_top UUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .irq_src_i   (irq_src),
    .irq_ready_i (irq_ready),
    .kill_req_i  (kill_req),
    .irq_req_o   (irq_req),
    .irq_priv_o  (irq_priv),
    .irq_cause_o (irq_cause),
    .kill_ack_o  (kill_ack)
  );

  bind clic_irq_ctrl clic_checker i_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .hart_state_i (hart_state_i),
    .sel_irq_i    (sel_irq_i),
    .irq_ready_i  (irq_ready_i),
    .kill_req_i   (kill_req_i),
    .irq_req_i    (irq_req_o),
    .irq_cause_i  (irq_cause_o),
    .kill_ack_i   (kill_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;  // LCG step
    return rand_state;
  endfunction

  function automatic clic_pkg::level_t max_level(clic_pkg::level_t a, clic_pkg::level_t b);
    return (a > b) ? a : b;
  endfunction

  // Downward scan with >= so the lowest id wins a tie
  function automatic clic_pkg::clic_irq_t pick_expected();
    clic_pkg::clic_irq_t best;
    best = '0;
    for (int i = clic_pkg::NumSrc - 1; i >= 0; i--) begin
      if (src_m[i] && ie_m[i] && (!best.valid || lvl_m[i] >= best.level)) begin
        best.valid = 1'b1;
        best.id    = clic_pkg::irq_id_t'(i);
        best.level = lvl_m[i];
        best.priv  = clic_pkg::priv_lvl_t'(prv_m[i]);
      end
    end
    return best;
  endfunction

  function automatic logic expect_request(clic_pkg::clic_irq_t s);
    logic is_m, is_s;
    is_m = s.valid && (s.priv == clic_pkg::PrivM);
    is_s = s.valid && (s.priv == clic_pkg::PrivS);
    case (hpriv_m)
      2'd3: return is_m && (s.level > max_level(mth_m, mil_m));
      2'd1: return is_m || (is_s && sie_m && (s.level > max_level(sth_m, sil_m)));
      2'd0: return is_m || (is_s && sie_m);
      default: return 1'b0;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  // ----------------------------------------
  // APB and source drivers
  // ----------------------------------------
  task automatic apb_xfer(input logic wr, input clic_pkg::addr_t a, input clic_pkg::data_t d,
                          output clic_pkg::data_t rd, output logic err);
    @(posedge clk_i);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: d};  // Setup
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    rd  = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    check("pready", 1, apb_rsp.pready);  // No wait states
    @(posedge clk_i);
    apb_req <= '0;  // Write lands on this edge
  endtask

  task automatic write_reg(input clic_pkg::addr_t a, input clic_pkg::data_t d);
    clic_pkg::data_t rd;
    logic err;
    apb_xfer(1'b1, a, d, rd, err);
    check("pslverr", 0, err);
  endtask

  task automatic read_check(input clic_pkg::addr_t a, input clic_pkg::data_t exp);
    clic_pkg::data_t rd;
    logic err;
    apb_xfer(1'b0, a, '0, rd, err);
    check("pslverr", 0, err);
    check("prdata", exp, rd);
  endtask

  task automatic write_src_cfg(input int i, input logic ie, input logic [1:0] pr,
                               input clic_pkg::level_t lvl);
    write_reg(clic_pkg::addr_t'(clic_pkg::SrcCfgBase + i * clic_pkg::SrcCfgStride),
              {8'b0, lvl, 6'b0, pr, 7'b0, ie});
    ie_m[i]  = ie;
    prv_m[i] = pr;
    lvl_m[i] = lvl;
  endtask

  // Config word with the raw source in bit 31
  task automatic read_src_cfg(input int i);
    read_check(clic_pkg::addr_t'(clic_pkg::SrcCfgBase + i * clic_pkg::SrcCfgStride),
               {src_m[i], 7'b0, lvl_m[i], 6'b0, prv_m[i], 7'b0, ie_m[i]});
  endtask

  // Half the levels fall in 0x80..0x87 to force ties
  task automatic random_cfg(input int i);
    logic [31:0] r;
    r = next_rand();
    write_src_cfg(i, r[0] | r[1], r[9:8], r[31] ? r[23:16] : {5'b10000, r[18:16]});
  endtask

  task automatic write_hart(input logic [1:0] pr, input logic sie);
    write_reg(clic_pkg::HartPrivAddr, {23'b0, sie, 6'b0, pr});
    hpriv_m = pr;
    sie_m   = sie;
  endtask

  task automatic write_thresh(input clic_pkg::level_t m, input clic_pkg::level_t s);
    write_reg(clic_pkg::ThreshAddr, {16'b0, s, m});
    mth_m = m;
    sth_m = s;
  endtask

  task automatic write_status(input clic_pkg::level_t ml, input clic_pkg::level_t sl);
    write_reg(clic_pkg::StatusAddr, {16'b0, sl, ml});
    mil_m = ml;
    sil_m = sl;
  endtask

  task automatic drive_src(input logic [clic_pkg::NumSrc-1:0] v);
    @(posedge clk_i);
    irq_src <= v;
    src_m = v;
  endtask

  // Arbiter register takes one edge, then sample mid-cycle
  task automatic settle();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic check_outputs();
    clic_pkg::clic_irq_t s;
    s = pick_expected();
    check("irq_req_o", expect_request(s), irq_req);
    if (s.valid) begin
      check("irq_cause_o", {1'b1, 7'b0, s.level, 12'b0, s.id}, irq_cause);
      check("irq_priv_o", s.priv, irq_priv);
    end
  endtask

  // Same threshold in M and S, same handler level in mil and sil
  task automatic try_hart(input logic [1:0] pr, input logic sie,
                          input clic_pkg::level_t th, input clic_pkg::level_t il);
    write_hart(pr, sie);
    write_thresh(th, th);
    write_status(il, il);
    settle();
    check_outputs();
  endtask

  task automatic read_hart_regs();
    read_check(clic_pkg::HartPrivAddr, {23'b0, sie_m, 6'b0, hpriv_m});
    read_check(clic_pkg::ThreshAddr, {16'b0, sth_m, mth_m});
    read_check(clic_pkg::StatusAddr, {16'b0, sil_m, mil_m});
  endtask

  task automatic end_test(input string name);
    $display("test %-8s done, %0d errors", name, errors - err_mark);
    tests++;
    err_mark = errors;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [31:0] r;
    clic_pkg::data_t rd;
    logic err;
    rand_state = 32'h21c0_a2b4;
    errors = 0;
    checks = 0;
    tests = 0;
    err_mark = 0;
    rst_ni = 1'b0;
    apb_req = '0;
    irq_src = '0;
    irq_ready = 1'b0;
    kill_req = 1'b0;
    src_m = '0;
    hpriv_m = 2'd3;  // Hart comes out of reset in M
    sie_m = 1'b0;
    {mth_m, sth_m, mil_m, sil_m} = '0;
    for (int i = 0; i < clic_pkg::NumSrc; i++) begin
      ie_m[i] = 1'b0;
      prv_m[i] = 2'd0;
      lvl_m[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Register access, bit 31 shows the raw source
    r = next_rand();
    drive_src(r[15:0]);
    for (int i = 0; i < clic_pkg::NumSrc; i++) random_cfg(i);
    for (int i = 0; i < clic_pkg::NumSrc; i++) read_src_cfg(i);
    r = next_rand();
    write_hart(2'd1, 1'b1);
    write_thresh(r[7:0], r[15:8]);
    write_status(r[23:16], r[31:24]);
    read_hart_regs();
    apb_xfer(1'b1, 12'h200, 32'hffff_ffff, rd, err);  // Unmapped
    check("pslverr", 1, err);
    apb_xfer(1'b0, 12'h200, '0, rd, err);
    check("pslverr", 1, err);
    read_hart_regs();
    for (int i = 0; i < clic_pkg::NumSrc; i++) read_src_cfg(i);
    end_test("regs");

    // Arbitration in U-mode so most winners raise a request
    write_hart(2'd0, 1'b1);
    repeat (4) begin
      for (int i = 0; i < clic_pkg::NumSrc; i++) random_cfg(i);
      repeat (8) begin
        r = next_rand();
        drive_src(r[31:16]);
        settle();
        check_outputs();
      end
    end
    end_test("arbiter");

    // M-mode trigger against mintthresh and mil
    write_hart(2'd3, 1'b0);
    repeat (16) begin
      r = next_rand();
      write_thresh(r[7:0], r[15:8]);
      write_status(r[16] ? r[23:16] : 8'h00, r[31:24]);
      random_cfg(int'(r[27:24]));
      r = next_rand();
      drive_src(r[31:16]);
      settle();
      check_outputs();
    end
    // Lone M source at 0x40 around the limit from either side
    write_src_cfg(0, 1'b1, 2'd3, 8'h40);
    drive_src(16'h0001);
    try_hart(2'd3, 1'b0, 8'h40, 8'h00);
    try_hart(2'd3, 1'b0, 8'h3f, 8'h00);
    try_hart(2'd3, 1'b0, 8'h3f, 8'h40);
    try_hart(2'd3, 1'b0, 8'h00, 8'h3f);
    write_src_cfg(0, 1'b1, 2'd1, 8'h40);  // S source stays masked
    try_hart(2'd3, 1'b1, 8'h00, 8'h00);
    end_test("m_mode");

    // S-mode first, then U-mode
    for (int m = 0; m < 2; m++) begin
      repeat (12) begin
        r = next_rand();
        write_hart((m == 0) ? 2'd1 : 2'd0, r[0]);
        write_thresh(r[15:8], r[23:16]);
        write_status(r[31:24], r[25] ? r[7:0] : 8'h00);
        random_cfg(int'(r[19:16]));
        r = next_rand();
        drive_src(r[31:16]);
        settle();
        check_outputs();
      end
    end
    // Lone S source at 0x40
    write_src_cfg(0, 1'b1, 2'd1, 8'h40);
    drive_src(16'h0001);
    try_hart(2'd1, 1'b1, 8'h40, 8'h00);
    try_hart(2'd1, 1'b1, 8'h3f, 8'h00);
    try_hart(2'd1, 1'b1, 8'h00, 8'h40);
    try_hart(2'd1, 1'b1, 8'h00, 8'h3f);
    try_hart(2'd1, 1'b0, 8'h00, 8'h00);
    try_hart(2'd0, 1'b1, 8'hff, 8'hff);  // U ignores thresholds
    try_hart(2'd0, 1'b0, 8'h00, 8'h00);
    // M source below every threshold
    write_src_cfg(0, 1'b1, 2'd3, 8'h10);
    try_hart(2'd1, 1'b0, 8'hff, 8'hff);
    try_hart(2'd0, 1'b0, 8'hff, 8'hff);
    end_test("s_u_mode");

    // Kill handshake
    drive_src('0);
    write_hart(2'd3, 1'b0);
    write_thresh(8'h00, 8'h00);
    write_status(8'h00, 8'h00);
    write_src_cfg(0, 1'b1, 2'd3, 8'hff);
    settle();
    @(posedge clk_i);
    irq_ready <= 1'b1;  // Retire anything left from earlier tests
    @(posedge clk_i);
    irq_ready <= 1'b0;
    @(posedge clk_i);
    kill_req <= 1'b1;
    @(negedge clk_i);
    check("kill_ack_o", 1, kill_ack);  // Idle, same-cycle ack
    @(posedge clk_i);
    kill_req <= 1'b0;
    drive_src(16'h0001);
    settle();
    check("irq_req_o", 1, irq_req);
    @(posedge clk_i);
    kill_req <= 1'b1;
    irq_src <= '0;
    src_m = '0;
    @(negedge clk_i);
    check("kill_ack_o", 0, kill_ack);  // Request still up
    @(negedge clk_i);
    check("irq_req_o", 0, irq_req);
    check("kill_ack_o", 0, kill_ack);  // In flight, no ready yet
    @(posedge clk_i);
    irq_ready <= 1'b1;
    @(negedge clk_i);
    check("kill_ack_o", 0, kill_ack);
    @(posedge clk_i);
    irq_ready <= 1'b0;
    @(negedge clk_i);
    check("kill_ack_o", 1, kill_ack);  // Flag cleared by ready
    @(posedge clk_i);
    kill_req <= 1'b0;
    // Ready in the first request cycle leaves nothing in flight
    drive_src(16'h0001);
    @(posedge clk_i);
    irq_ready <= 1'b1;
    irq_src <= '0;
    src_m = '0;
    @(negedge clk_i);
    check("irq_req_o", 1, irq_req);
    @(posedge clk_i);
    irq_ready <= 1'b0;
    kill_req <= 1'b1;
    @(negedge clk_i);
    check("kill_ack_o", 1, kill_ack);
    @(posedge clk_i);
    kill_req <= 1'b0;
    end_test("kill");

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, UUT.i_irq_ctrl.i_checker.fail_cnt);
    if (errors == 0 && UUT.i_irq_ctrl.i_checker.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("timeout: tests still running after %0d cycles", WatchdogCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: source/clic_arbiter.sv
/*
  Picks the enabled, asserted source with the highest level and
  registers it. Lowest id wins a tie, valid drops with no candidate.
*/
`timescale 1ns/1ns

module clic_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [clic_pkg::NumSrc-1:0]              irq_src_i,
  input  clic_pkg::src_cfg_t [clic_pkg::NumSrc-1:0] src_cfg_i,
  output clic_pkg::clic_irq_t                      sel_irq_o
);

  logic [clic_pkg::NumSrc-1:0] cand;  // Asserted and enabled
  clic_pkg::clic_irq_t sel_d, sel_q;

  // ----------------------------------------
  // Candidate mask
  // ----------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < clic_pkg::NumSrc; i++) begin
      cand[i] = irq_src_i[i] & src_cfg_i[i].ie;
    end
  end

  // ----------------------------------------
  // Max-level search
  // ----------------------------------------
  // Ascending scan, strict compare keeps the lower id on equal levels
  always_comb begin
    sel_d = '0;
    for (int unsigned i = 0; i < clic_pkg::NumSrc; i++) begin
      if (cand[i] && (!sel_d.valid || (src_cfg_i[i].level > sel_d.level))) begin
        sel_d.valid = 1'b1;
        sel_d.id    = clic_pkg::irq_id_t'(i);
        sel_d.level = src_cfg_i[i].level;
        sel_d.priv  = src_cfg_i[i].priv;
      end
    end
  end

  // One cycle from source or config change to selection
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_d;
    end
  end

  assign sel_irq_o = sel_q;

endmodule

// File: source/clic_irq_ctrl.sv
/*
  Decides whether the selected interrupt is taken at the current
  privilege and thresholds, builds the cause word and answers
  kill requests from the pipeline.
*/
`timescale 1ns/1ns

module clic_irq_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  clic_pkg::hart_state_t hart_state_i,
  input  clic_pkg::clic_irq_t   sel_irq_i,
  input  logic                  irq_ready_i,  // Pipeline took the irq
  input  logic                  kill_req_i,
  output logic                  irq_req_o,
  output clic_pkg::priv_lvl_t   irq_priv_o,
  output clic_pkg::cause_t      irq_cause_o,
  output logic                  kill_ack_o
);

  clic_pkg::level_t m_thresh, s_thresh;  // Effective thresholds
  logic is_m_src, is_s_src;
  logic inflight_d, inflight_q;

  // ----------------------------------------
  // Trigger
  // ----------------------------------------
  // A running handler level masks like a threshold, take the larger
  assign m_thresh = (hart_state_i.mintthresh > hart_state_i.mil) ?
                    hart_state_i.mintthresh : hart_state_i.mil;
  assign s_thresh = (hart_state_i.sintthresh > hart_state_i.sil) ?
                    hart_state_i.sintthresh : hart_state_i.sil;

  assign is_m_src = sel_irq_i.valid && (sel_irq_i.priv == clic_pkg::PrivM);
  assign is_s_src = sel_irq_i.valid && (sel_irq_i.priv == clic_pkg::PrivS);  // Reserved 2 is neither

  always_comb begin
    irq_req_o = 1'b0;
    case (hart_state_i.priv_lvl)
      clic_pkg::PrivM: begin
        irq_req_o = is_m_src && (sel_irq_i.level > m_thresh);  // S sources masked
      end
      clic_pkg::PrivS: begin
        irq_req_o = is_m_src ||
                    (is_s_src && hart_state_i.sie && (sel_irq_i.level > s_thresh));
      end
      clic_pkg::PrivU: begin
        irq_req_o = is_m_src || (is_s_src && hart_state_i.sie);  // No U threshold
      end
      default: irq_req_o = 1'b0;  // Reserved hart mode takes nothing
    endcase
  end

  // ----------------------------------------
  // Cause packing
  // ----------------------------------------
  assign irq_cause_o = {1'b1,                                 // Interrupt flag
                        {(clic_pkg::XLen - 25){1'b0}},
                        sel_irq_i.level,                      // Bits 23:16
                        {(16 - clic_pkg::IdWidth){1'b0}},
                        sel_irq_i.id};

  assign irq_priv_o = sel_irq_i.priv;

  // ----------------------------------------
  // Kill control
  // ----------------------------------------
  // Ack only when the pipeline holds no irq and none is offered now
  assign kill_ack_o = kill_req_i & ~inflight_q & ~irq_req_o;

  // Set on a request not accepted at once, cleared by accept or kill
  assign inflight_d = inflight_q ? ~(irq_ready_i | kill_ack_o) : (irq_req_o & ~irq_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

// File: source/clic_pkg.sv
/*
  Shared sizes, types and APB address map of the CLIC slice.
  All RTL files refer to these through scoped names.
*/
package clic_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int unsigned NumSrc  = 16;  // Interrupt sources
  localparam int unsigned IdWidth = 4;   // Bits of a source id
  localparam int unsigned XLen    = 32;  // Cause word width

  typedef logic [7:0]         level_t;   // Level or threshold
  typedef logic [IdWidth-1:0] irq_id_t;
  typedef logic [XLen-1:0]    cause_t;
  typedef logic [11:0]        addr_t;    // APB address
  typedef logic [31:0]        data_t;    // APB data

  // Privilege encoding as in the RISC-V spec, 2 is reserved
  typedef enum logic [1:0] {
    PrivU = 2'd0,
    PrivS = 2'd1,
    PrivM = 2'd3
  } priv_lvl_t;

  // ----------------------------------------
  // Bus and config structs
  // ----------------------------------------
  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic      ie;     // Source enable
    priv_lvl_t priv;   // Target mode
    level_t    level;
  } src_cfg_t;

  // Hart state normally held in the CSR file
  typedef struct packed {
    priv_lvl_t priv_lvl;
    logic      sie;
    level_t    mintthresh;
    level_t    sintthresh;
    level_t    mil;         // mintstatus.mil
    level_t    sil;         // mintstatus.sil
  } hart_state_t;

  // Selected interrupt, arbiter output
  typedef struct packed {
    logic      valid;
    irq_id_t   id;
    level_t    level;
    priv_lvl_t priv;
  } clic_irq_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam addr_t       SrcCfgBase   = 12'h000;
  localparam int unsigned SrcCfgStride = 4;       // One word per source
  localparam addr_t       HartPrivAddr = 12'h100; // priv 1:0, sie 8
  localparam addr_t       ThreshAddr   = 12'h104; // mintthresh 7:0, sintthresh 15:8
  localparam addr_t       StatusAddr   = 12'h108; // mil 7:0, sil 15:8

endpackage

// File: source/clic_reg_bank.sv
/*
  APB slave of the CLIC slice. Holds per-source config words and the
  hart state registers, no wait states, pslverr on unmapped addresses.
*/
`timescale 1ns/1ns

module clic_reg_bank (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  clic_pkg::apb_req_t                       apb_req_i,
  output clic_pkg::apb_rsp_t                       apb_rsp_o,
  input  logic [clic_pkg::NumSrc-1:0]              irq_src_i,   // Raw source levels
  output clic_pkg::src_cfg_t [clic_pkg::NumSrc-1:0] src_cfg_o,
  output clic_pkg::hart_state_t                    hart_state_o
);

  logic access;                      // APB access phase
  logic wr_en;
  logic src_hit, priv_hit, thresh_hit, status_hit, hit;
  clic_pkg::addr_t   src_off;        // Offset into source window
  clic_pkg::irq_id_t src_idx;
  clic_pkg::data_t   rdata;

  clic_pkg::src_cfg_t [clic_pkg::NumSrc-1:0] cfg_q;
  clic_pkg::hart_state_t                     hart_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign access  = apb_req_i.psel & apb_req_i.penable;
  assign src_off = apb_req_i.paddr - clic_pkg::SrcCfgBase;
  assign src_idx = src_off[clic_pkg::IdWidth+1:2];  // Word index

  assign src_hit    = (src_off < clic_pkg::NumSrc * clic_pkg::SrcCfgStride) &&
                      (src_off[1:0] == 2'b00);       // Aligned words only
  assign priv_hit   = (apb_req_i.paddr == clic_pkg::HartPrivAddr);
  assign thresh_hit = (apb_req_i.paddr == clic_pkg::ThreshAddr);
  assign status_hit = (apb_req_i.paddr == clic_pkg::StatusAddr);
  assign hit        = src_hit | priv_hit | thresh_hit | status_hit;

  assign wr_en = access & apb_req_i.pwrite & hit;  // Unmapped writes dropped

  // ----------------------------------------
  // Register storage
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      hart_q <= '{priv_lvl: clic_pkg::PrivM, default: '0};  // Hart starts in M
    end else if (wr_en) begin
      if (src_hit) begin
        cfg_q[src_idx].ie    <= apb_req_i.pwdata[0];
        cfg_q[src_idx].priv  <= clic_pkg::priv_lvl_t'(apb_req_i.pwdata[9:8]); // 2 kept
        cfg_q[src_idx].level <= apb_req_i.pwdata[23:16];
      end
      if (priv_hit) begin
        hart_q.priv_lvl <= clic_pkg::priv_lvl_t'(apb_req_i.pwdata[1:0]);
        hart_q.sie      <= apb_req_i.pwdata[8];
      end
      if (thresh_hit) begin
        hart_q.mintthresh <= apb_req_i.pwdata[7:0];
        hart_q.sintthresh <= apb_req_i.pwdata[15:8];
      end
      if (status_hit) begin
        hart_q.mil <= apb_req_i.pwdata[7:0];
        hart_q.sil <= apb_req_i.pwdata[15:8];
      end
    end
  end

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb begin
    rdata = '0;  // Unmapped reads return zero
    if (src_hit) begin
      rdata = {irq_src_i[src_idx],         // Raw input in bit 31
               7'b0,
               cfg_q[src_idx].level,
               6'b0,
               cfg_q[src_idx].priv,
               7'b0,
               cfg_q[src_idx].ie};
    end else if (priv_hit) begin
      rdata = {23'b0, hart_q.sie, 6'b0, hart_q.priv_lvl};
    end else if (thresh_hit) begin
      rdata = {16'b0, hart_q.sintthresh, hart_q.mintthresh};
    end else if (status_hit) begin
      rdata = {16'b0, hart_q.sil, hart_q.mil};
    end
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = access;           // Never stalls
  assign apb_rsp_o.pslverr = access & ~hit;

  assign src_cfg_o    = cfg_q;
  assign hart_state_o = hart_q;

endmodule

// File: source/clic_top.sv
/*
  CLIC slice top level. APB register bank feeds the source arbiter
  and the interrupt control block, which talks to the pipeline.
*/
`timescale 1ns/1ns

module clic_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  clic_pkg::apb_req_t          apb_req_i,
  output clic_pkg::apb_rsp_t          apb_rsp_o,
  input  logic [clic_pkg::NumSrc-1:0] irq_src_i,    // Level-sensitive sources
  input  logic                        irq_ready_i,
  input  logic                        kill_req_i,
  output logic                        irq_req_o,
  output clic_pkg::priv_lvl_t         irq_priv_o,
  output clic_pkg::cause_t            irq_cause_o,
  output logic                        kill_ack_o
);

  clic_pkg::src_cfg_t [clic_pkg::NumSrc-1:0] src_cfg;     // Per-source config
  clic_pkg::hart_state_t                     hart_state;  // Mode and thresholds
  clic_pkg::clic_irq_t                       sel_irq;     // Registered winner

  // Config and hart state registers
  clic_reg_bank i_reg_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .irq_src_i    (irq_src_i),
    .src_cfg_o    (src_cfg),
    .hart_state_o (hart_state)
  );

  clic_arbiter i_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_src_i (irq_src_i),
    .src_cfg_i (src_cfg),
    .sel_irq_o (sel_irq)
  );

  // Trigger, cause and kill handshake
  clic_irq_ctrl i_irq_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .hart_state_i (hart_state),
    .sel_irq_i    (sel_irq),
    .irq_ready_i  (irq_ready_i),
    .kill_req_i   (kill_req_i),
    .irq_req_o    (irq_req_o),
    .irq_priv_o   (irq_priv_o),
    .irq_cause_o  (irq_cause_o),
    .kill_ack_o   (kill_ack_o)
  );

endmodule
